/* retire_tail.f */
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/stage_reg.sv
rtl/late_alu.sv
rtl/commit_stage.sv
rtl/gpr_file.sv
rtl/retire_tail.sv
verification/retire_checker.sv
verification/tb_retire_tail.sv

/* run.sh */
#!/usr/bin/env bash
# build the retire tail testbench with Verilator, run it, then check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_retire_tail \
    -f retire_tail.f

./obj_dir/Vtb_retire_tail | tee sim.log

if grep -qx "RESULT: PASS" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1

/* verification/retire_stimulus.txt */
// test op dest src_a src_b imm use_imm risk pc exp_wen exp_data
// all hex, rows of one test together, a row starting with 0 ends the list
1 7 06 00 05 00000000 0 0 00001000 1 00000000
2 7 01 00 00 12345678 1 0 00001004 1 12345678
2 0 02 00 00 00001111 1 0 00001008 1 00001111
2 1 03 01 00 00000078 1 0 0000100c 1 12345600
2 2 04 01 00 0f0f0f0f 1 0 00001010 1 02040608
2 3 05 02 00 f0000000 1 0 00001014 1 f0001111
2 4 07 01 00 ffffffff 1 0 00001018 1 edcba987
2 5 08 02 00 00000004 1 0 0000101c 1 00011110
2 6 09 01 00 00000008 1 0 00001020 1 00123456
2 0 0a 01 02 00000000 0 0 00001024 1 12346789
2 1 0b 02 01 00000000 0 0 00001028 1 edcbba99
2 2 0c 05 07 00000000 0 0 0000102c 1 e0000101
2 6 10 05 08 00000000 0 0 00001030 1 0000f000
3 7 14 00 00 00000005 1 0 00001034 1 00000005
3 0 14 14 00 00000003 1 0 00001038 1 00000008
3 5 15 14 14 00000000 0 0 0000103c 1 00000800
3 1 16 15 14 00000000 0 0 00001040 1 000007f8
3 3 17 16 15 00000000 0 0 00001044 1 00000ff8
4 0 00 00 00 00000055 1 0 00001048 0 00000055
4 7 18 00 00 00000000 0 0 0000104c 1 00000000
5 7 01 00 00 0000dead 1 1 00001050 0 0000dead
5 7 19 00 01 00000000 0 0 00001054 1 12345678
6 0 1a 01 00 00000001 1 0 00001058 1 12345679
6 0 1b 1a 1a 00000000 0 0 0000105c 1 2468acf2
6 1 1c 1b 01 00000000 0 0 00001060 1 1234567a
6 4 1d 1c 1a 00000000 0 0 00001064 1 00000003
6 6 1e 1b 1d 00000000 0 0 00001068 1 048d159e
0 0 00 00 00 00000000 0 0 00000000 0 00000000

/* verification/tb_retire_tail.sv */
/* testbench for the retire tail: plays the stimulus file into the op port under
   random or free trace back-pressure, while retire_checker compares the trace */
`timescale 1ns/100ps

module tb_retire_tail
    import isa_pkg::*;
();

    // test that runs with the trace never stalled
    localparam logic [7:0] full_rate_test = 8'd3;
    localparam int         wait_limit = 200;

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 op_valid;
    logic                 op_ready;
    logic [alu_op_w-1:0]  op_code;
    logic [gpr_num_w-1:0] op_dest;
    logic [gpr_num_w-1:0] op_src_a;
    logic [gpr_num_w-1:0] op_src_b;
    logic [word_w-1:0]    op_imm;
    logic                 op_use_imm;
    logic                 op_risk;
    logic [word_w-1:0]    op_pc;
    logic                 trace_valid;
    logic                 trace_ready = 1'b0;
    logic [word_w-1:0]    trace_pc;
    logic                 trace_wen;
    logic [gpr_num_w-1:0] trace_wnum;
    logic [word_w-1:0]    trace_wdata;
    logic                 risk;
    logic                 exp_wen;
    logic [word_w-1:0]    exp_data;
    logic                 done_pulse;
    logic [7:0]           done_test;
    logic                 report_pulse;
    int                   pending;
    int                   errors;
    logic                 full_rate;
    logic                 timed_out;
    int                   ops_sent;
    integer               seed = 32'h5d0d9c0b;
    logic [31:0]          rand_word = '0;
    // eleven words per stimulus row
    logic [31:0]          stim [1024] = '{default: '0};
    logic [9:0]           ptr;

    always #20 clk = ~clk;

    // trace back-pressure, free in the full rate test
    always @(posedge clk) begin
        rand_word = $random(seed);
        trace_ready <= full_rate || rand_word[0];
    end

    retire_tail UUT (
        .clk(clk), .rst(rst),
        .op_valid_i(op_valid), .op_ready_o(op_ready), .op_code_i(op_code),
        .op_dest_i(op_dest), .op_src_a_i(op_src_a), .op_src_b_i(op_src_b),
        .op_imm_i(op_imm), .op_use_imm_i(op_use_imm), .op_risk_i(op_risk), .op_pc_i(op_pc),
        .trace_valid_o(trace_valid), .trace_ready_i(trace_ready), .trace_pc_o(trace_pc),
        .trace_wen_o(trace_wen), .trace_wnum_o(trace_wnum), .trace_wdata_o(trace_wdata),
        .risk_o(risk)
    );

    retire_checker u_checker (
        .clk(clk), .rst(rst),
        .op_valid_i(op_valid), .op_ready_i(op_ready), .op_dest_i(op_dest),
        .op_risk_i(op_risk), .op_pc_i(op_pc), .exp_wen_i(exp_wen), .exp_data_i(exp_data),
        .trace_valid_i(trace_valid), .trace_ready_i(trace_ready), .trace_pc_i(trace_pc),
        .trace_wen_i(trace_wen), .trace_wnum_i(trace_wnum), .trace_wdata_i(trace_wdata),
        .risk_i(risk), .done_i(done_pulse), .done_test_i(done_test),
        .report_i(report_pulse), .pending_o(pending), .errors_o(errors)
    );

    //////////////////////////////
    // op driver
    //////////////////////////////
    // presents the row at ptr and holds it until accepted
    task automatic send_op();
        int waited;
        waited = 0;
        op_valid   <= 1'b1;
        op_code    <= stim[ptr + 10'd1][alu_op_w-1:0];
        op_dest    <= stim[ptr + 10'd2][gpr_num_w-1:0];
        op_src_a   <= stim[ptr + 10'd3][gpr_num_w-1:0];
        op_src_b   <= stim[ptr + 10'd4][gpr_num_w-1:0];
        op_imm     <= stim[ptr + 10'd5];
        op_use_imm <= stim[ptr + 10'd6][0];
        op_risk    <= stim[ptr + 10'd7][0];
        op_pc      <= stim[ptr + 10'd8];
        exp_wen    <= stim[ptr + 10'd9][0];
        exp_data   <= stim[ptr + 10'd10];
        @(posedge clk);
        while (!op_ready) begin
            if (waited == wait_limit) begin
                $display("timeout: op_ready_o stayed low for %0d cycles", wait_limit);
                timed_out = 1'b1;
                break;
            end
            waited++;
            @(posedge clk);
        end
        ops_sent++;
    endtask

    // all accepted ops retired
    task automatic wait_drain();
        int waited;
        waited = 0;
        @(posedge clk);
        while (pending != 0) begin
            if (waited == wait_limit) begin
                $display("timeout: %0d ops never left the pipeline", pending);
                timed_out = 1'b1;
                break;
            end
            waited++;
            @(posedge clk);
        end
    endtask

    task automatic run_test();
        logic [7:0] test;
        test = stim[ptr][7:0];
        @(posedge clk);
        full_rate <= (test == full_rate_test);
        @(posedge clk);
        // back to back, one row per accept
        while (stim[ptr][7:0] == test && !timed_out) begin
            send_op();
            ptr = ptr + 10'd11;
        end
        op_valid <= 1'b0;
        if (!timed_out) begin
            wait_drain();
        end
        done_test  <= test;
        done_pulse <= 1'b1;
        @(posedge clk);
        done_pulse <= 1'b0;
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////
    initial begin
        rst = 1'b0;
        op_valid = 1'b0;
        op_code = '0;
        op_dest = '0;
        op_src_a = '0;
        op_src_b = '0;
        op_imm = '0;
        op_use_imm = 1'b0;
        op_risk = 1'b0;
        op_pc = '0;
        exp_wen = 1'b0;
        exp_data = '0;
        done_pulse = 1'b0;
        done_test = '0;
        report_pulse = 1'b0;
        full_rate = 1'b0;
        timed_out = 1'b0;
        ops_sent = 0;
        ptr = '0;
        $readmemh("verification/retire_stimulus.txt", stim);
        repeat (8) @(posedge clk);
        rst <= 1'b1;
        repeat (2) @(posedge clk);
        while (stim[ptr] != '0 && !timed_out) begin
            run_test();
        end
        if (ops_sent == 0) begin
            $display("no operations found in the stimulus file");
        end
        @(posedge clk);
        report_pulse <= 1'b1;
        @(posedge clk);
        report_pulse <= 1'b0;
        @(posedge clk);
        if (timed_out || errors != 0 || ops_sent == 0) begin
            $display("RESULT: FAIL");
        end else begin
            $display("RESULT: PASS");
        end
        $finish;
    end

endmodule

/* verification/retire_checker.sv */
/* retire trace checker: queues every accepted operation and compares each trace
   handshake with the queue head; prints a line per test and a closing count line */
`timescale 1ns/100ps

module retire_checker
    import isa_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    // operation port, watched for accepts
    input  logic                 op_valid_i,
    input  logic                 op_ready_i,
    input  logic [gpr_num_w-1:0] op_dest_i,
    input  logic                 op_risk_i,
    input  logic [word_w-1:0]    op_pc_i,
    // expected result of the op on the port
    input  logic                 exp_wen_i,
    input  logic [word_w-1:0]    exp_data_i,
    // retire trace
    input  logic                 trace_valid_i,
    input  logic                 trace_ready_i,
    input  logic [word_w-1:0]    trace_pc_i,
    input  logic                 trace_wen_i,
    input  logic [gpr_num_w-1:0] trace_wnum_i,
    input  logic [word_w-1:0]    trace_wdata_i,
    input  logic                 risk_i,
    // test control
    input  logic                 done_i,
    input  logic [7:0]           done_test_i,
    input  logic                 report_i,
    output int                   pending_o,
    output int                   errors_o
);

    typedef struct packed {
        logic [word_w-1:0]    pc;
        logic                 wen;
        logic [gpr_num_w-1:0] wnum;
        logic [word_w-1:0]    data;
        logic                 risk;
    } expect_t;

    expect_t expect_q[$];
    expect_t head;
    expect_t incoming;
    logic    rst_q = 1'b0;
    int      test_items = 0;
    int      test_errors = 0;
    int      total_items = 0;
    int      total_errors = 0;
    int      tests_done = 0;

    task automatic compare_value(input string name, input logic [word_w-1:0] got,
                                 input logic [word_w-1:0] exp,
                                 input logic [word_w-1:0] at_pc);
        if (got !== exp) begin
            $display("mismatch %s at pc %h: got %h, expected %h", name, at_pc, got, exp);
            test_errors++;
            total_errors++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("error: %s", what);
        test_errors++;
        total_errors++;
    endtask

    //////////////////////////////
    // per-edge checks
    //////////////////////////////
    always @(posedge clk) begin
        rst_q <= rst;
        if (rst) begin
            // first edge out of reset, pipeline must be empty
            if (!rst_q) begin
                compare_value("trace_valid_o", 32'(trace_valid_i), '0, '0);
                compare_value("risk_o", 32'(risk_i), '0, '0);
                compare_value("trace_wen_o", 32'(trace_wen_i), '0, '0);
                compare_value("op_ready_o", 32'(op_ready_i), 32'd1, '0);
            end
            if (risk_i && !trace_valid_i) begin
                report_failure("risk_o is high with no trace item present");
            end
            // free trace means the issue side can always take an op
            if (trace_ready_i && !op_ready_i) begin
                report_failure("op_ready_o is low although the trace is not stalled");
            end
            // retire first, an op taken this edge cannot retire on it
            if (trace_valid_i && trace_ready_i) begin
                if (expect_q.size() == 0) begin
                    report_failure("a trace item retired with nothing expected");
                end else begin
                    head = expect_q.pop_front();
                    compare_value("trace_pc_o", trace_pc_i, head.pc, head.pc);
                    compare_value("trace_wen_o", 32'(trace_wen_i), 32'(head.wen), head.pc);
                    compare_value("trace_wnum_o", 32'(trace_wnum_i), 32'(head.wnum), head.pc);
                    compare_value("trace_wdata_o", trace_wdata_i, head.data, head.pc);
                    compare_value("risk_o", 32'(risk_i), 32'(head.risk), head.pc);
                    test_items++;
                    total_items++;
                end
            end
            if (op_valid_i && op_ready_i) begin
                incoming.pc   = op_pc_i;
                incoming.wen  = exp_wen_i;
                incoming.wnum = op_dest_i;
                incoming.data = exp_data_i;
                incoming.risk = op_risk_i;
                expect_q.push_back(incoming);
            end
            if (done_i) begin
                $display("test %0d: %0d items retired, %0d errors",
                         done_test_i, test_items, test_errors);
                test_items = 0;
                test_errors = 0;
                tests_done++;
            end
            if (report_i) begin
                $display("checked %0d items in %0d tests, %0d errors",
                         total_items, tests_done, total_errors);
            end
        end
        pending_o <= expect_q.size();
        errors_o  <= total_errors;
    end

endmodule

/* rtl/retire_tail.sv */
/* top of the pipeline tail: issue register, late ALU, commit stage and register file;
   takes operations on a valid/ready port and retires them on the trace port */
`timescale 1ns/100ps

module retire_tail
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    // operation input
    input  logic                 op_valid_i,
    output logic                 op_ready_o,
    input  logic [alu_op_w-1:0]  op_code_i,
    input  logic [gpr_num_w-1:0] op_dest_i,
    input  logic [gpr_num_w-1:0] op_src_a_i,
    input  logic [gpr_num_w-1:0] op_src_b_i,
    input  logic [word_w-1:0]    op_imm_i,
    input  logic                 op_use_imm_i,
    input  logic                 op_risk_i,
    input  logic [word_w-1:0]    op_pc_i,
    // retire trace
    output logic                 trace_valid_o,
    input  logic                 trace_ready_i,
    output logic [word_w-1:0]    trace_pc_o,
    output logic                 trace_wen_o,
    output logic [gpr_num_w-1:0] trace_wnum_o,
    output logic [word_w-1:0]    trace_wdata_o,
    output logic                 risk_o
);

    issue_entry_t         op_entry;
    issue_entry_t         issue_entry;
    logic                 issue_valid;
    commit_entry_t        alu_entry;
    logic                 commit_allowin;
    logic [gpr_num_w-1:0] rd_num_a;
    logic [gpr_num_w-1:0] rd_num_b;
    logic [word_w-1:0]    rd_data_a;
    logic [word_w-1:0]    rd_data_b;
    logic                 fwd_valid;
    logic [gpr_num_w-1:0] fwd_num;
    logic [word_w-1:0]    fwd_data;
    logic                 wr_en;
    logic [gpr_num_w-1:0] wr_num;
    logic [word_w-1:0]    wr_data;

    // loose op fields into one entry
    assign op_entry = '{op: op_code_i, dest: op_dest_i, src_a: op_src_a_i,
                        src_b: op_src_b_i, imm: op_imm_i, use_imm: op_use_imm_i,
                        risk: op_risk_i, pc: op_pc_i};

    //////////////////////////////
    // issue register
    //////////////////////////////
    stage_reg #(.payload_t(issue_entry_t)) u_issue_reg (
        .clk(clk), .rst(rst),
        .in_valid_i(op_valid_i), .in_data_i(op_entry), .allowin_o(op_ready_o),
        .out_valid_o(issue_valid), .out_data_o(issue_entry),
        .next_allowin_i(commit_allowin)
    );

    // re-execute
    late_alu u_late_alu (
        .clk(clk), .rst(rst), .issue_valid_i(issue_valid), .issue_entry_i(issue_entry),
        .rd_num_a_o(rd_num_a), .rd_num_b_o(rd_num_b),
        .rd_data_a_i(rd_data_a), .rd_data_b_i(rd_data_b),
        .fwd_valid_i(fwd_valid), .fwd_num_i(fwd_num), .fwd_data_i(fwd_data),
        .commit_entry_o(alu_entry)
    );

    //////////////////////////////
    // write-back
    //////////////////////////////
    commit_stage u_commit (
        .clk(clk), .rst(rst),
        .in_valid_i(issue_valid), .commit_entry_i(alu_entry), .allowin_o(commit_allowin),
        .trace_valid_o(trace_valid_o), .trace_ready_i(trace_ready_i),
        .trace_pc_o(trace_pc_o), .trace_wen_o(trace_wen_o),
        .trace_wnum_o(trace_wnum_o), .trace_wdata_o(trace_wdata_o), .risk_o(risk_o),
        .fwd_valid_o(fwd_valid), .fwd_num_o(fwd_num), .fwd_data_o(fwd_data),
        .wr_en_o(wr_en), .wr_num_o(wr_num), .wr_data_o(wr_data)
    );

    gpr_file u_gpr (
        .clk(clk), .rst(rst),
        .rd_num_a_i(rd_num_a), .rd_num_b_i(rd_num_b),
        .rd_data_a_o(rd_data_a), .rd_data_b_o(rd_data_b),
        .wr_en_i(wr_en), .wr_num_i(wr_num), .wr_data_i(wr_data)
    );

endmodule

/* rtl/gpr_file.sv */
/* general register file, 32 x 32 bit, two combinational read ports and one write port;
   register 0 reads as zero and all entries clear on reset */
`timescale 1ns/100ps

module gpr_file
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    // read ports
    input  logic [gpr_num_w-1:0] rd_num_a_i,
    input  logic [gpr_num_w-1:0] rd_num_b_i,
    output logic [word_w-1:0]    rd_data_a_o,
    output logic [word_w-1:0]    rd_data_b_o,
    // write port
    input  logic                 wr_en_i,
    input  logic [gpr_num_w-1:0] wr_num_i,
    input  logic [word_w-1:0]    wr_data_i
);

    logic [word_w-1:0] regs [gpr_count];

    //////////////////////////////
    // write
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst) begin
            regs <= '{default: '0};
        end else if (wr_en_i && (wr_num_i != zero_reg)) begin
            regs[wr_num_i] <= wr_data_i;
        end
    end

    //////////////////////////////
    // read
    //////////////////////////////
    // r0 forced zero on the read side too
    assign rd_data_a_o = (rd_num_a_i == zero_reg) ? '0 : regs[rd_num_a_i];
    assign rd_data_b_o = (rd_num_b_i == zero_reg) ? '0 : regs[rd_num_b_i];

    // commit stage filters r0 targets before they get here
    no_r0_write: assert property (
        @(posedge clk) disable iff (!rst)
        wr_en_i |-> wr_num_i != zero_reg
    ) else $error("gpr_file write requested to r0");

endmodule

/* rtl/commit_stage.sv */
/* write-back stage: holds one result, presents it as the retire trace and writes the
   register file on the trace handshake; also feeds the forward path to the late ALU */
`timescale 1ns/100ps

module commit_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    // from late ALU
    input  logic                 in_valid_i,
    input  commit_entry_t        commit_entry_i,
    output logic                 allowin_o,
    // retire trace
    output logic                 trace_valid_o,
    input  logic                 trace_ready_i,
    output logic [word_w-1:0]    trace_pc_o,
    output logic                 trace_wen_o,
    output logic [gpr_num_w-1:0] trace_wnum_o,
    output logic [word_w-1:0]    trace_wdata_o,
    output logic                 risk_o,
    // forward path
    output logic                 fwd_valid_o,
    output logic [gpr_num_w-1:0] fwd_num_o,
    output logic [word_w-1:0]    fwd_data_o,
    // register file write
    output logic                 wr_en_o,
    output logic [gpr_num_w-1:0] wr_num_o,
    output logic [word_w-1:0]    wr_data_o
);

    logic          held_valid;
    commit_entry_t held;
    logic          will_write;
    logic          retire;

    //////////////////////////////
    // result register
    //////////////////////////////
    // trace consumer is the downstream side
    stage_reg #(
        .payload_t(commit_entry_t)
    ) u_commit_reg (
        .clk           (clk),
        .rst           (rst),
        .in_valid_i    (in_valid_i),
        .in_data_i     (commit_entry_i),
        .allowin_o     (allowin_o),
        .out_valid_o   (held_valid),
        .out_data_o    (held),
        .next_allowin_i(trace_ready_i)
    );

    //////////////////////////////
    // write rule
    //////////////////////////////
    // risky ops and r0 targets retire without a write
    assign will_write = held_valid && (held.dest != zero_reg) && !held.risk;
    assign retire     = held_valid && trace_ready_i;

    // trace
    assign trace_valid_o = held_valid;
    assign trace_pc_o    = held.pc;
    assign trace_wen_o   = will_write;
    assign trace_wnum_o  = held.dest;
    assign trace_wdata_o = held.data;
    assign risk_o        = held_valid && held.risk;

    // unwritten result visible to the stage behind
    assign fwd_valid_o = will_write;
    assign fwd_num_o   = held.dest;
    assign fwd_data_o  = held.data;

    // write lands on the handshake edge
    assign wr_en_o   = retire && will_write;
    assign wr_num_o  = held.dest;
    assign wr_data_o = held.data;

endmodule

/* rtl/late_alu.sv */
/* re-execute stage logic: reads operands from the register file or the commit stage
   forward path, applies the opcode and builds the commit entry in the same cycle */
`timescale 1ns/100ps

module late_alu
    import isa_pkg::*;
    import pipe_pkg::*;
(
    // clock only used by the opcode check
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 issue_valid_i,
    input  issue_entry_t         issue_entry_i,
    // register file read
    output logic [gpr_num_w-1:0] rd_num_a_o,
    output logic [gpr_num_w-1:0] rd_num_b_o,
    input  logic [word_w-1:0]    rd_data_a_i,
    input  logic [word_w-1:0]    rd_data_b_i,
    // forward from commit
    input  logic                 fwd_valid_i,
    input  logic [gpr_num_w-1:0] fwd_num_i,
    input  logic [word_w-1:0]    fwd_data_i,
    output commit_entry_t        commit_entry_o
);

    logic              hit_a;
    logic              hit_b;
    logic [word_w-1:0] opnd_a;
    logic [word_w-1:0] reg_b;
    logic [word_w-1:0] opnd_b;
    logic [word_w-1:0] result;

    assign rd_num_a_o = issue_entry_i.src_a;
    assign rd_num_b_o = issue_entry_i.src_b;

    //////////////////////////////
    // operand select
    //////////////////////////////
    // fwd_valid is never set for r0, so r0 always comes from the file
    assign hit_a  = fwd_valid_i && (fwd_num_i == issue_entry_i.src_a);
    assign hit_b  = fwd_valid_i && (fwd_num_i == issue_entry_i.src_b);
    assign opnd_a = hit_a ? fwd_data_i : rd_data_a_i;
    assign reg_b  = hit_b ? fwd_data_i : rd_data_b_i;
    // immediate overrides source b
    assign opnd_b = issue_entry_i.use_imm ? issue_entry_i.imm : reg_b;

    //////////////////////////////
    // arithmetic
    //////////////////////////////
    always_comb begin
        case (issue_entry_i.op)
            op_add:    result = opnd_a + opnd_b;
            op_sub:    result = opnd_a - opnd_b;
            op_and:    result = opnd_a & opnd_b;
            op_or:     result = opnd_a | opnd_b;
            op_xor:    result = opnd_a ^ opnd_b;
            op_sll:    result = opnd_a << opnd_b[shamt_w-1:0];
            op_srl:    result = opnd_a >> opnd_b[shamt_w-1:0];
            op_pass_b: result = opnd_b;
            default:   result = '0;
        endcase
    end

    // dest, risk and pc ride along unchanged
    assign commit_entry_o.dest = issue_entry_i.dest;
    assign commit_entry_o.data = result;
    assign commit_entry_o.risk = issue_entry_i.risk;
    assign commit_entry_o.pc   = issue_entry_i.pc;

    // issue register must never present a garbage opcode
    op_known: assert property (
        @(posedge clk) disable iff (!rst)
        issue_valid_i |-> !$isunknown(issue_entry_i.op)
    ) else $error("late_alu got unknown opcode");

endmodule

/* rtl/stage_reg.sv */
/* one-entry pipeline register with valid/allowin handshake, typed by its payload;
   used for both the issue register and the commit stage */
`timescale 1ns/100ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    // upstream side
    input  logic     in_valid_i,
    input  payload_t in_data_i,
    output logic     allowin_o,
    // downstream side
    output logic     out_valid_o,
    output payload_t out_data_o,
    input  logic     next_allowin_i
);

    logic     has_data;
    logic     need_update;
    logic     need_clear;
    payload_t payload;

    //////////////////////////////
    // handshake
    //////////////////////////////
    // free when empty or when the held item leaves this cycle
    assign allowin_o   = !has_data || next_allowin_i;
    assign need_update = allowin_o && in_valid_i;
    // item leaves and nothing replaces it
    assign need_clear  = allowin_o && !in_valid_i;

    always_ff @(posedge clk) begin
        if (!rst) begin
            has_data <= 1'b0;
        end else if (need_update) begin
            has_data <= 1'b1;
        end else if (need_clear) begin
            has_data <= 1'b0;
        end
    end

    // payload only moves with a new item
    always_ff @(posedge clk) begin
        if (need_update) begin
            payload <= in_data_i;
        end
    end

    assign out_valid_o = has_data;
    assign out_data_o  = payload;

    //////////////////////////////
    // checks
    //////////////////////////////
    // stalled item must not change under the consumer
    hold_stable: assert property (
        @(posedge clk) disable iff (!rst)
        out_valid_o && !next_allowin_i |=> out_valid_o && $stable(out_data_o)
    ) else $error("stage_reg payload changed while stalled");

endmodule

/* rtl/pipe_pkg.sv */
/* payload types carried by the issue and commit stage registers, and the register
   write rule shared by the commit stage and the register file */
package pipe_pkg;

    import isa_pkg::*;

    // operation as taken from the input port
    typedef struct packed {
        logic [alu_op_w-1:0]  op;
        logic [gpr_num_w-1:0] dest;
        logic [gpr_num_w-1:0] src_a;
        logic [gpr_num_w-1:0] src_b;
        logic [word_w-1:0]    imm;
        logic                 use_imm;
        logic                 risk;
        logic [word_w-1:0]    pc;
    } issue_entry_t;

    // computed result waiting for write-back
    typedef struct packed {
        logic [gpr_num_w-1:0] dest;
        logic [word_w-1:0]    data;
        logic                 risk;
        logic [word_w-1:0]    pc;
    } commit_entry_t;

    // hard zero register, never written
    localparam logic [gpr_num_w-1:0] zero_reg = '0;

endpackage

/* rtl/isa_pkg.sv */
/* integer ISA constants for the retire tail: word and register widths plus the late ALU
   opcode encoding, imported by every RTL module and by the testbench */
package isa_pkg;

    //////////////////////////////
    // widths
    //////////////////////////////
    localparam int word_w    = 32;
    localparam int gpr_count = 32;
    localparam int gpr_num_w = 5;
    localparam int alu_op_w  = 3;
    // shift amount taken from the low bits of operand b
    localparam int shamt_w   = 5;

    //////////////////////////////
    // late ALU opcodes
    //////////////////////////////
    localparam logic [alu_op_w-1:0] op_add    = 3'd0;
    localparam logic [alu_op_w-1:0] op_sub    = 3'd1;
    localparam logic [alu_op_w-1:0] op_and    = 3'd2;
    localparam logic [alu_op_w-1:0] op_or     = 3'd3;
    localparam logic [alu_op_w-1:0] op_xor    = 3'd4;
    localparam logic [alu_op_w-1:0] op_sll    = 3'd5;
    localparam logic [alu_op_w-1:0] op_srl    = 3'd6;
    localparam logic [alu_op_w-1:0] op_pass_b = 3'd7;

endpackage
